/* pat_pkg.sv */
`default_nettype none

package pat_pkg;

	// ==================================================
	// widths and sizes
	// ==================================================
	localparam int i_width     = 20; // instruction word
	localparam int i_adr_width = 8;  // 256 program words
	localparam int d_width     = 8;  // accumulator and data memory word
	localparam int d_adr_width = 4;  // 16 data words
	localparam int num_inputs  = 3;  // in port sources

	localparam logic [3:0] escape_code = 4'b1111; // steps into the next opcode space

	// ==================================================
	// opcode spaces
	// ==================================================
	// codes 9, 10 and 12 are unused and decode as nop
	typedef enum logic [3:0] {
		i8_or        = 4'b0000,
		i8_and       = 4'b0001,
		i8_addm      = 4'b0010,
		i8_subm      = 4'b0011,
		i8_add       = 4'b0100,
		i8_sub       = 4'b0101,
		i8_ldi       = 4'b0110,
		i8_ldm       = 4'b0111,
		i8_bf        = 4'b1000,
		i8_stm       = 4'b1011,
		i8_orm       = 4'b1101,
		i8_andm      = 4'b1110,
		i8_prefix_i3 = 4'b1111
	} op_i8_e;

	typedef enum logic [3:0] {
		i3_shl       = 4'b0000,
		i3_shlo      = 4'b0001,
		i3_shr       = 4'b0010,
		i3_asr       = 4'b0011,
		i3_in        = 4'b0101,
		i3_out       = 4'b1000,
		i3_prefix_i0 = 4'b1111
	} op_i3_e;

	typedef enum logic [3:0] {
		i0_not  = 4'b0000,
		i0_test = 4'b0010,
		i0_nop  = 4'b1111
	} op_i0_e;

	typedef enum logic [1:0] {
		cond_z  = 2'd0,
		cond_nz = 2'd1, // zero flag clear
		cond_n  = 2'd2,
		cond_al = 2'd3
	} cond_e;

	typedef enum logic [3:0] {
		alu_or, alu_and, alu_not, alu_add, alu_sub,
		alu_shl, alu_shlo, alu_shr, alu_asr, alu_pass_b
	} alu_op_e;

	// ==================================================
	// bundles between blocks
	// ==================================================
	typedef struct packed {
		logic                   valid;
		logic [i_adr_width-1:0] addr;
		logic [i_width-1:0]     instr;
	} imem_write_t;

	typedef struct packed {
		logic                   valid;
		logic [i_adr_width-1:0] pc;
		logic [i_width-1:0]     instr;
	} fetch_out_t;

	typedef struct packed {
		logic                   valid;
		logic [i_adr_width-1:0] pc;
		cond_e                  cond;
		alu_op_e                alu_op;
		logic                   use_mem_b; // b from data memory
		logic                   use_in;    // b from in port
		logic                   write_acc;
		logic                   write_mem;
		logic                   is_branch;
		logic                   is_out;
		logic                   is_test;
		logic [7:0]             imm8;      // imm3 already zero-extended for i3
	} decoded_t;

	typedef struct packed {
		logic [num_inputs-1:0][d_width-1:0] data;
	} in_ports_t;

	typedef struct packed {
		logic               valid;
		logic [d_width-1:0] data;
	} out_event_t;

	typedef struct packed {
		logic                   taken;
		logic [i_adr_width-1:0] target;
	} branch_req_t;

endpackage

`default_nettype wire

/* data_mem.sv */
`default_nettype none

module data_mem (
	input  logic                           clk,
	input  logic [pat_pkg::d_adr_width-1:0] i_addr,
	input  logic [pat_pkg::d_width-1:0]     i_wdata,
	input  logic                           i_we,
	output logic [pat_pkg::d_width-1:0]     o_rdata
);
	import pat_pkg::*;

	logic [d_width-1:0] mem [1 << d_adr_width]; // no reset, contents undefined until stored

	assign o_rdata = mem[i_addr]; // same-cycle read for the memory operand forms

	// write lands on the edge, so a load right after a store sees the new word
	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_addr] <= i_wdata;
	end

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu (
	input  logic [pat_pkg::d_width-1:0] i_a,
	input  logic [pat_pkg::d_width-1:0] i_b,
	input  pat_pkg::alu_op_e            i_op,
	output logic [pat_pkg::d_width-1:0] o_y
);
	import pat_pkg::*;

	logic [2:0]         sh;        // shift amount from b
	logic [d_width-1:0] ones_mask; // low sh bits set, for shlo

	assign sh        = i_b[2:0];
	assign ones_mask = ~({d_width{1'b1}} << sh);

	always_comb
	begin
		case (i_op)
			alu_or:     o_y = i_a | i_b;
			alu_and:    o_y = i_a & i_b;
			alu_not:    o_y = ~i_a; // b ignored
			alu_add:    o_y = i_a + i_b; // wraps at 256
			alu_sub:    o_y = i_a - i_b;
			alu_shl:    o_y = i_a << sh;
			alu_shlo:   o_y = (i_a << sh) | ones_mask; // vacated bits filled with ones
			alu_shr:    o_y = i_a >> sh;
			alu_asr:    o_y = $unsigned($signed(i_a) >>> sh); // sign fill
			alu_pass_b: o_y = i_b; // ldi, ldm, in
			default:    o_y = i_a;
		endcase
	end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none

module fetch_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_run,
	input  pat_pkg::imem_write_t i_load,
	input  logic                 i_stall,
	input  pat_pkg::branch_req_t i_branch,
	output pat_pkg::fetch_out_t  o_fetch
);
	import pat_pkg::*;

	logic [i_width-1:0]     imem [1 << i_adr_width]; // program store
	logic [i_adr_width-1:0] pc;
	fetch_out_t             fetch_q;

	// program load, only while the core is halted
	always_ff @(posedge clk)
	begin
		if (i_load.valid && !i_run)
			imem[i_load.addr] <= i_load.instr;
	end

	// ==================================================
	// pc and fetch register
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc      <= '0;
			fetch_q <= '0;
		end
		else if (!i_run)
		begin
			pc            <= '0; // parked at the start of the program
			fetch_q.valid <= 1'b0;
		end
		else if (i_branch.taken)
		begin
			pc            <= i_branch.target;
			fetch_q.valid <= 1'b0; // word read this cycle is on the wrong path
		end
		else if (!i_stall)
		begin
			fetch_q.valid <= 1'b1;
			fetch_q.pc    <= pc;
			fetch_q.instr <= imem[pc]; // word shows one cycle after its address
			pc            <= pc + 1'b1;
		end
		// stalled: pc and fetch_q hold
	end

	assign o_fetch = fetch_q;

endmodule

`default_nettype wire

/* decode_unit.sv */
`default_nettype none

module decode_unit (
	input  logic                clk,
	input  logic                reset,
	input  pat_pkg::fetch_out_t i_fetch,
	input  logic                i_stall,
	input  logic                i_flush,
	output pat_pkg::decoded_t   o_dec
);
	import pat_pkg::*;

	logic [i_width-1:0] word;
	op_i8_e             op8;
	op_i3_e             op3;
	op_i0_e             op0;
	logic               is_i8;
	logic               is_i3;
	decoded_t           dec_next;
	decoded_t           dec_q;

	assign word  = i_fetch.instr;
	assign op8   = op_i8_e'(word[11:8]);
	assign op3   = op_i3_e'(word[7:4]); // overlaps imm8, only meaningful past the prefix
	assign op0   = op_i0_e'(word[3:0]);
	assign is_i8 = (word[11:8] != escape_code);
	assign is_i3 = !is_i8 && (word[7:4] != escape_code);
	// anything else is i0

	always_comb
	begin
		dec_next        = '0; // no effects unless an opcode matches, i.e. nop
		dec_next.valid  = i_fetch.valid;
		dec_next.pc     = i_fetch.pc;
		dec_next.cond   = cond_e'(word[14:13]);
		dec_next.alu_op = alu_pass_b;
		dec_next.imm8   = is_i8 ? word[7:0] : {5'b0, word[2:0]}; // imm3 zero-extended
		if (is_i8)
		begin
			case (op8)
				i8_or:   {dec_next.alu_op, dec_next.write_acc} = {alu_or, 1'b1};
				i8_and:  {dec_next.alu_op, dec_next.write_acc} = {alu_and, 1'b1};
				i8_add:  {dec_next.alu_op, dec_next.write_acc} = {alu_add, 1'b1};
				i8_sub:  {dec_next.alu_op, dec_next.write_acc} = {alu_sub, 1'b1};
				i8_ldi:  dec_next.write_acc = 1'b1; // pass_b of the immediate
				i8_addm: {dec_next.alu_op, dec_next.use_mem_b, dec_next.write_acc} = {alu_add, 2'b11};
				i8_subm: {dec_next.alu_op, dec_next.use_mem_b, dec_next.write_acc} = {alu_sub, 2'b11};
				i8_orm:  {dec_next.alu_op, dec_next.use_mem_b, dec_next.write_acc} = {alu_or, 2'b11};
				i8_andm: {dec_next.alu_op, dec_next.use_mem_b, dec_next.write_acc} = {alu_and, 2'b11};
				i8_ldm:  {dec_next.use_mem_b, dec_next.write_acc} = 2'b11;
				i8_stm:  dec_next.write_mem = 1'b1;
				i8_bf:   dec_next.is_branch = 1'b1;
				default: ; // codes 9, 10 and 12 decode as nop
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				i3_shl:  {dec_next.alu_op, dec_next.write_acc} = {alu_shl, 1'b1};
				i3_shlo: {dec_next.alu_op, dec_next.write_acc} = {alu_shlo, 1'b1};
				i3_shr:  {dec_next.alu_op, dec_next.write_acc} = {alu_shr, 1'b1};
				i3_asr:  {dec_next.alu_op, dec_next.write_acc} = {alu_asr, 1'b1};
				i3_in:   {dec_next.use_in, dec_next.write_acc} = 2'b11; // imm3 is the one-hot select
				i3_out:  dec_next.is_out = 1'b1;
				default: ;
			endcase
		end
		else
		begin
			case (op0)
				i0_not:  {dec_next.alu_op, dec_next.write_acc} = {alu_not, 1'b1};
				i0_test: dec_next.is_test = 1'b1;
				default: ; // i0_nop and unused codes
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			dec_q <= '0;
		else if (i_flush)
			dec_q.valid <= 1'b0; // younger than a taken branch
		else if (!i_stall)
			dec_q <= dec_next;
	end

	assign o_dec = dec_q;

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none

module execute_stage (
	input  logic                            clk,
	input  logic                            reset,
	input  pat_pkg::decoded_t               i_dec,
	input  pat_pkg::in_ports_t              i_inputs,
	input  logic                            i_out_ready,
	input  logic [pat_pkg::d_width-1:0]     i_mem_rdata,
	output logic [pat_pkg::d_adr_width-1:0] o_mem_addr,
	output logic [pat_pkg::d_width-1:0]     o_mem_wdata,
	output logic                            o_mem_we,
	output pat_pkg::branch_req_t            o_branch,
	output logic                            o_stall,
	output pat_pkg::out_event_t             o_out
);
	import pat_pkg::*;

	logic [d_width-1:0] acc;
	logic               z_flag;
	logic               n_flag;
	out_event_t         out_q;
	logic               cond_ok;
	logic               commit;  // instruction takes effect this cycle
	logic [d_width-1:0] in_sel;
	logic [d_width-1:0] alu_b;
	logic [d_width-1:0] alu_y;

	// ==================================================
	// predication and operand select
	// ==================================================
	always_comb
	begin
		case (i_dec.cond)
			cond_z:  cond_ok = z_flag;
			cond_nz: cond_ok = !z_flag;
			cond_n:  cond_ok = n_flag;
			default: cond_ok = 1'b1; // al
		endcase
	end

	assign o_stall = out_q.valid && !i_out_ready; // out not taken yet, freeze everything
	assign commit  = i_dec.valid && cond_ok && !o_stall;

	always_comb
	begin
		case (i_dec.imm8[2:0])
			3'b010:  in_sel = i_inputs.data[1];
			3'b100:  in_sel = i_inputs.data[2];
			default: in_sel = i_inputs.data[0]; // 001 and anything not one-hot
		endcase
	end

	assign alu_b = i_dec.use_mem_b ? i_mem_rdata :
	               i_dec.use_in    ? in_sel      :
	                                 i_dec.imm8;

	alu alu_inst (
		.i_a  (acc),
		.i_b  (alu_b),
		.i_op (i_dec.alu_op),
		.o_y  (alu_y)
	);

	// memory port, address straight from imm8
	assign o_mem_addr  = i_dec.imm8[d_adr_width-1:0];
	assign o_mem_wdata = acc;
	assign o_mem_we    = commit && i_dec.write_mem;

	// bf is relative to its own pc
	assign o_branch.taken  = commit && i_dec.is_branch;
	assign o_branch.target = i_dec.pc + i_adr_width'(signed'(i_dec.imm8));

	// ==================================================
	// architectural state and out register
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc    <= '0;
			z_flag <= 1'b0;
			n_flag <= 1'b0;
			out_q  <= '0;
		end
		else
		begin
			if (commit && i_dec.write_acc)
				acc <= alu_y;
			if (commit && i_dec.is_test)
			begin
				z_flag <= (acc == '0);
				n_flag <= acc[d_width-1];
			end
			if (commit && i_dec.is_out)
			begin
				out_q.valid <= 1'b1; // only reachable when the slot is free or being taken
				out_q.data  <= acc;
			end
			else if (i_out_ready)
				out_q.valid <= 1'b0; // accepted
		end
	end

	assign o_out = out_q;

endmodule

`default_nettype wire

/* pat_core.sv */
`default_nettype none

module pat_core (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_run,
	input  pat_pkg::imem_write_t i_load,
	input  pat_pkg::in_ports_t   i_inputs,
	input  logic                 i_out_ready,
	output pat_pkg::out_event_t  o_out
);
	import pat_pkg::*;

	fetch_out_t             fetch;
	decoded_t               dec;
	branch_req_t            branch;
	logic                   stall;       // out port back-pressure
	logic [d_adr_width-1:0] mem_addr;
	logic [d_width-1:0]     mem_wdata;
	logic [d_width-1:0]     mem_rdata;
	logic                   mem_we;

	// ==================================================
	// fetch -> decode -> execute
	// ==================================================
	fetch_unit fetch_unit_inst (
		.clk      (clk),
		.reset    (reset),
		.i_run    (i_run),
		.i_load   (i_load),
		.i_stall  (stall),
		.i_branch (branch),
		.o_fetch  (fetch)
	);

	decode_unit decode_unit_inst (
		.clk     (clk),
		.reset   (reset),
		.i_fetch (fetch),
		.i_stall (stall),
		.i_flush (branch.taken), // drop the instruction behind a taken bf
		.o_dec   (dec)
	);

	execute_stage execute_stage_inst (
		.clk         (clk),
		.reset       (reset),
		.i_dec       (dec),
		.i_inputs    (i_inputs),
		.i_out_ready (i_out_ready),
		.i_mem_rdata (mem_rdata),
		.o_mem_addr  (mem_addr),
		.o_mem_wdata (mem_wdata),
		.o_mem_we    (mem_we),
		.o_branch    (branch),
		.o_stall     (stall),
		.o_out       (o_out)
	);

	data_mem data_mem_inst (
		.clk     (clk),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.i_we    (mem_we),
		.o_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

/* pat_assert.sv */
`default_nettype none

module pat_assert (
	input logic                clk,
	input logic                reset,
	input logic                i_out_ready,
	input pat_pkg::out_event_t i_out
);

	int assert_failures = 0; // read by the testbench at the end

	// ==================================================
	// out port handshake
	// ==================================================
	// a held word stays put until the consumer takes it
	property out_held;
		@(posedge clk) disable iff (reset)
		(i_out.valid && !i_out_ready) |=> (i_out.valid && $stable(i_out.data));
	endproperty

	assert property (out_held)
	else
	begin
		$error("out port dropped valid or changed data while ready was low");
		assert_failures++;
	end

	assert property (@(posedge clk) reset |=> !i_out.valid) // cleared by reset
	else
	begin
		$error("out valid seen during reset");
		assert_failures++;
	end

	assert property (@(posedge clk) disable iff (reset) i_out.valid |-> !$isunknown(i_out.data))
	else
	begin
		$error("out data unknown while valid");
		assert_failures++;
	end

endmodule

bind pat_core pat_assert pat_assert_inst (
	.clk         (clk),
	.reset       (reset),
	.i_out_ready (i_out_ready),
	.i_out       (o_out)
);

`default_nettype wire

/* pat_checker.sv */
`default_nettype none

module pat_checker (
	input  logic                        clk,
	input  logic                        reset,
	input  pat_pkg::out_event_t         i_out,
	input  logic                        i_out_ready,
	input  logic                        i_push,      // queue one expected value
	input  logic [pat_pkg::d_width-1:0] i_push_data,
	input  logic                        i_test_done, // close the running test
	input  logic [3:0]                  i_test_id,
	output int                          o_pending,
	output int                          o_checked,
	output int                          o_errors,
	output int                          o_tests_passed,
	output int                          o_tests_failed
);
	import pat_pkg::*;

	logic [d_width-1:0] exp_mem [256]; // expected values in acceptance order
	int                 wr_idx;
	int                 rd_idx;
	int                 test_outputs;
	int                 test_errors;
	logic [d_width-1:0] want;

	assign o_pending = wr_idx - rd_idx; // still owed by the DUT

	always @(posedge clk)
	begin
		if (reset)
		begin
			wr_idx         <= 0;
			rd_idx         <= 0;
			test_outputs   <= 0;
			test_errors    <= 0;
			o_checked      <= 0;
			o_errors       <= 0;
			o_tests_passed <= 0;
			o_tests_failed <= 0;
		end
		else
		begin
			if (i_push)
			begin
				exp_mem[wr_idx[7:0]] <= i_push_data;
				wr_idx               <= wr_idx + 1;
			end
			// ==================================================
			// accepted output, compared in order
			// ==================================================
			if (i_out.valid && i_out_ready)
			begin
				test_outputs <= test_outputs + 1;
				o_checked    <= o_checked + 1;
				if (rd_idx == wr_idx)
				begin
					$display("FAIL t=%0t test %0d: unexpected output %02h", $time, i_test_id,
						i_out.data);
					test_errors <= test_errors + 1;
					o_errors    <= o_errors + 1;
				end
				else
				begin
					want   = exp_mem[rd_idx[7:0]];
					rd_idx <= rd_idx + 1;
					if (i_out.data !== want)
					begin
						$display("FAIL t=%0t test %0d: out %02h, expected %02h", $time,
							i_test_id, i_out.data, want);
						test_errors <= test_errors + 1;
						o_errors    <= o_errors + 1;
					end
				end
			end
			if (i_test_done) // one line per test
			begin
				if (test_errors == 0)
				begin
					$display("test %0d passed: %0d outputs", i_test_id, test_outputs);
					o_tests_passed <= o_tests_passed + 1;
				end
				else
				begin
					$display("test %0d failed: %0d of %0d outputs wrong", i_test_id,
						test_errors, test_outputs);
					o_tests_failed <= o_tests_failed + 1;
				end
				test_outputs <= 0;
				test_errors  <= 0;
			end
		end
	end

endmodule

`default_nettype wire

/* pat_tb.sv */
`default_nettype none

module pat_tb;
	import pat_pkg::*;

	logic               clk = 1'b0;
	logic               reset;
	logic               run;
	imem_write_t        load;
	in_ports_t          inputs;
	logic               out_ready;
	out_event_t         dut_out;
	logic               push;
	logic [d_width-1:0] push_data;
	logic               test_done;
	logic [3:0]         test_id;
	int                 pending;
	int                 checked;
	int                 errors;
	int                 tests_passed;
	int                 tests_failed;
	logic [31:0]        vec [512];  // records from the vector file
	int                 idx;        // next record
	int                 n_tests;
	int                 n_expected;
	int                 watchdog_cycles;
	bit                 vectors_ready = 1'b0;
	logic [31:0]        rng_state;
	logic               file_error;

	always #50 clk = ~clk; // 100 per cycle

	pat_core pat_core_inst (
		.clk         (clk),
		.reset       (reset),
		.i_run       (run),
		.i_load      (load),
		.i_inputs    (inputs),
		.i_out_ready (out_ready),
		.o_out       (dut_out)
	);

	pat_checker pat_checker_inst (
		.clk            (clk),
		.reset          (reset),
		.i_out          (dut_out),
		.i_out_ready    (out_ready),
		.i_push         (push),
		.i_push_data    (push_data),
		.i_test_done    (test_done),
		.i_test_id      (test_id),
		.o_pending      (pending),
		.o_checked      (checked),
		.o_errors       (errors),
		.o_tests_passed (tests_passed),
		.o_tests_failed (tests_failed)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ==================================================
	// per-test steps, all with run low until the program is in
	// ==================================================
	task automatic load_program();
		while (vec[idx][31:28] == 4'h1)
		begin
			@(posedge clk);
			load <= imem_write_t'({1'b1, vec[idx][27:20], vec[idx][19:0]});
			idx = idx + 1;
		end
		@(posedge clk);
		load.valid <= 1'b0;
	endtask

	task automatic queue_expected();
		while (vec[idx][31:28] == 4'h3)
		begin
			@(posedge clk);
			push      <= 1'b1;
			push_data <= vec[idx][7:0];
			idx = idx + 1;
		end
		@(posedge clk);
		push <= 1'b0;
	endtask

	task automatic run_test();
		@(posedge clk);
		test_id <= vec[idx][27:24];
		inputs  <= in_ports_t'(vec[idx][23:0]);
		idx = idx + 1;
		load_program();
		queue_expected();
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		while (pending != 0)
			@(posedge clk); // checker counts them off
		repeat (20) @(posedge clk); // quiet window, any extra output shows up here
		run <= 1'b0;
		@(posedge clk);
		test_done <= 1'b1;
		@(posedge clk);
		test_done <= 1'b0;
	endtask

	// random back-pressure, seed 8
	initial
	begin
		rng_state = 32'd8;
		out_ready <= 1'b0;
		forever
		begin
			@(posedge clk);
			rng_state = xorshift32(rng_state);
			out_ready <= rng_state[3] | rng_state[11]; // high about 3 in 4
		end
	end

	initial
	begin
		wait (vectors_ready);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: run stopped after %0d cycles with %0d outputs still owed",
			watchdog_cycles, pending);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		reset     <= 1'b1;
		run       <= 1'b0;
		load      <= '0;
		inputs    <= '0;
		push      <= 1'b0;
		push_data <= '0;
		test_done <= 1'b0;
		test_id   <= '0;
		file_error = 1'b0;
		$readmemh("pat_vectors.txt", vec);
		idx        = 0;
		n_tests    = 0;
		n_expected = 0;
		while (idx < 512 && vec[idx][31:28] != 4'hf) // size the run
		begin
			if (vec[idx][31:28] == 4'h2)
				n_tests = n_tests + 1;
			if (vec[idx][31:28] == 4'h3)
				n_expected = n_expected + 1;
			idx = idx + 1;
		end
		watchdog_cycles = 40 * n_expected + 200;
		vectors_ready   = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		idx = 0;
		while (vec[idx][31:28] == 4'h2)
			run_test();
		if (vec[idx][31:28] !== 4'hf)
		begin
			$display("vector file: record %0d (%08h) is not a test header or the end", idx,
				vec[idx]);
			file_error = 1'b1;
		end
		repeat (2) @(posedge clk);
		$display("summary: %0d tests passed, %0d failed, %0d outputs checked, %0d errors",
			tests_passed, tests_failed, checked, errors);
		if (!file_error && n_tests > 0 && errors == 0 && tests_failed == 0 &&
			tests_passed == n_tests && pat_core_inst.pat_assert_inst.assert_failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* pat_vectors.txt */
// columns: tag, then payload, as one 32-bit hex word per record
// 2T<in2><in1><in0> test header | 1<addr><instr> program word | 3....<vv> expected out | f end
// test 1: immediates, ldi add sub or and not
21000000
1000665a 10106f80 102064c0 10306f80 10406520 10506f80 10606005 10706f80
1080613c 10906f80 10a06ff0 10b06f80 10c06800
3000005a 3000001a 300000fa 300000ff 3000003c 300000c3
// test 2: shifts, amounts 0 to 7, sign fill and ones fill
22000000
10006696 10106f03 10206f80 10306696 10406f12 10506f80 10606696 10706f25
10806f80 10906696 10a06f31 10b06f80 10c06f34 10d06f80 10e06f00 10f06f80
11006696 11106f17 11206f80 1130666c 11406f36 11506f80 11606696 11706f37
11806f80 11906f06 11a06f80 11b06800
300000b0 3000005b 30000004 300000cb 300000fc 300000fc 3000007f 30000001
300000ff 300000c0
// test 3: data memory, store then load back to back at c and 3
23000000
10006611 10106b03 1020667e 10306b09 10406703 10506f80 10606640 10706209
10806f80 10906303 10a06f80 10b06d03 10c06f80 10d06e09 10e06f80 10f066a5
11006b0c 1110620c 11206f80 11306b03 11406203 11506f80 11606709 11706f80
11806800
30000011 300000be 300000ad 300000bd 3000003c 3000004a 30000094 3000007e
// test 4: in port selects, in2 c3 in1 b2 in0 a1
24c3b2a1
10006f51 10106f80 10206f52 10306f80 10406f54 10506f80 10606f50 10706f80
10806800
300000a1 300000b2 300000c3 300000a1
// test 5: predication after test, count loop, branch shadow
25000000
10006600 10106ff2 10200f80 10302655 10406f80 10504666 10600680 10706ff2
10804f80 10900f80 10a02f80 10b04621 10c06ff2 10d04f80 10e02501 10f06f80
11006603 11106f80 11206501 11306ff2 114028fd 11506677 11606f80 11706803
11806f80 11906f80 11a0660e 11b06f80 11c06800
30000000 30000000 30000080 30000080 30000020 30000003 30000002 30000001
30000077 3000000e
// test 6: back to back outs under random ready
26000000
10006608 10106f80 10206501 10306ff2 104028fd 10506f80 10606ff0 10706f80
10806f80 10906800
30000008 30000007 30000006 30000005 30000004 30000003 30000002 30000001
30000000 300000ff 300000ff
f0000000

/* compile.f */
pat_pkg.sv
data_mem.sv
alu.sv
fetch_unit.sv
decode_unit.sv
execute_stage.sv
pat_core.sv
pat_assert.sv
pat_checker.sv
pat_tb.sv
